/* icache.f */
+incdir+common
common/icache_pkg.sv
common/mem_bus_pkg.sv
icache/fetch_decode.sv
icache/icache_arrays.sv
icache/miss_control.sv
icache/fetch_response.sv
icache/icache_top.sv
dv/mem_model.sv
dv/icache_tb.sv

/* run.sh */
#!/bin/sh
# Builds the icache testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module icache_tb -f icache.f -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -q 'All tests passed!' sim.log; then
    echo "Simulation passed."
else
    echo "Simulation failed, see sim.log."
    exit 1
fi

/* dv/icache_tb.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import icache_pkg::*;
    import mem_bus_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int HOLD_CYCLES  = 5;
    localparam int HIT_LATENCY  = 2;
    localparam int TEST_BUDGET  = 40;

    typedef enum {FETCH, HOLD, FENCE} kind_t; // HOLD fetches with resp_ready held low.

    typedef struct {
        string  name;
        kind_t  kind;
        paddr_t addr;
        int     count;
        bit     expects_miss;
    } test_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_valid;
    fetch_req_t  req;
    logic        req_ready;
    logic        resp_valid;
    fetch_resp_t resp;
    logic        resp_ready;
    logic        ar_valid;
    mem_ar_t     ar;
    logic        ar_ready;
    logic        r_valid;
    mem_r_t      r;
    logic        fence_req;
    logic        fence_done;
    int          ar_count;
    paddr_t      last_addr;

    test_t tests[$];
    int    cycles        = 0;
    int    timeout_limit = 0;
    int    resp_count    = 0;
    int    fence_count   = 0;
    int    checks        = 0;
    int    mismatches    = 0;
    int    failures      = 0;
    int    exp_ars       = 0;
    int    exp_resps     = 0;
    int    exp_fences    = 0;

    always #10 clk = ~clk;

    icache_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .resp_ready (resp_ready),
        .ar_valid   (ar_valid),
        .ar         (ar),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r          (r),
        .fence_req  (fence_req),
        .fence_done (fence_done)
    );

    mem_model mem0 (
        .clk       (clk),
        .rst       (rst),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .ar_count  (ar_count),
        .last_addr (last_addr)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if ((timeout_limit > 0) && (cycles >= timeout_limit)) begin
            $display("Timeout after %0d cycles, a handshake never completed.", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // Handshakes counted where inputs and outputs are settled.
    always @(negedge clk) begin
        if (resp_valid && resp_ready) begin
            resp_count <= resp_count + 1;
        end
        if (fence_done) begin
            fence_count <= fence_count + 1;
        end
    end

    function automatic logic [`ICACHE_LINE_WORDS-1:0] expected_mask(input paddr_t addr,
                                                                    input int count);
        logic [`ICACHE_LINE_WORDS-1:0] mask;
        int off;
        off = int'(addr[`ICACHE_BYTE_BITS +: `ICACHE_OFF_BITS]);
        for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
            mask[i] = (i < count) && (i < `ICACHE_LINE_WORDS - off);
        end
        return mask;
    endfunction

    function automatic fetch_resp_t expected_resp(input paddr_t addr, input int count);
        fetch_resp_t exp;
        paddr_t      word_addr;
        exp       = '0;
        exp.en    = expected_mask(addr, count);
        word_addr = addr & ~paddr_t'(3);
        for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
            if (exp.en[i]) begin
                exp.words[i] = ~(word_addr + paddr_t'(4 * i));
            end
        end
        return exp;
    endfunction

    task automatic note_failure(input string msg);
        failures++;
        $display("ERROR %s", msg);
    endtask

    // Words outside the mask are don't-care.
    task automatic check_resp(input string name, input fetch_resp_t exp, input fetch_resp_t act);
        logic ok;
        ok = (act.en == exp.en);
        for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
            if (exp.en[i] && (act.words[i] !== exp.words[i])) begin
                ok = 1'b0;
            end
        end
        checks++;
        if (!ok) begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_miss_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            mismatches++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input paddr_t exp, input paddr_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            mismatches++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic add_test(input string name, input kind_t kind, input paddr_t addr,
                            input int count, input bit expects_miss);
        test_t t;
        t.name         = name;
        t.kind         = kind;
        t.addr         = addr;
        t.count        = count;
        t.expects_miss = expects_miss;
        tests.push_back(t);
    endtask

    task automatic build_table();
        add_test("cold_miss", FETCH, 32'h0000_0100, 4, 1'b1);
        add_test("warm_hit", FETCH, 32'h0000_0100, 4, 1'b0);
        add_test("off0_cnt1", FETCH, 32'h0000_0200, 1, 1'b1);
        add_test("off1_cnt2", FETCH, 32'h0000_0204, 2, 1'b0);
        add_test("off2_cnt3", FETCH, 32'h0000_0208, 3, 1'b0);
        add_test("off3_cnt4", FETCH, 32'h0000_020c, 4, 1'b0);
        add_test("off1_cnt4", FETCH, 32'h0000_0204, 4, 1'b0);
        add_test("off0_cnt3", FETCH, 32'h0000_0200, 3, 1'b0);
        add_test("off2_cnt1", FETCH, 32'h0000_0208, 1, 1'b0);
        // Lines A, B and C all map to set 5.
        add_test("lru_a", FETCH, 32'h0000_1050, 4, 1'b1);
        add_test("lru_b", FETCH, 32'h0000_2054, 3, 1'b1);
        add_test("lru_a_hit", FETCH, 32'h0000_1058, 2, 1'b0);
        add_test("lru_c", FETCH, 32'h0000_3050, 4, 1'b1);
        add_test("lru_a_kept", FETCH, 32'h0000_105c, 1, 1'b0);
        add_test("lru_b_evicted", FETCH, 32'h0000_2050, 4, 1'b1);
        add_test("fence", FENCE, 32'h0, 0, 1'b0);
        add_test("after_fence", FETCH, 32'h0000_0100, 4, 1'b1);
        add_test("after_fence_hit", FETCH, 32'h0000_0104, 2, 1'b0);
        add_test("hold_hit", HOLD, 32'h0000_0108, 2, 1'b0);
        add_test("hold_miss", HOLD, 32'h4000_0030, 4, 1'b1);
        add_test("after_hold", FETCH, 32'h4000_0034, 1, 1'b0);
    endtask

    task automatic run_fetch(input test_t t);
        fetch_resp_t exp;
        fetch_resp_t held;
        int          accept_cycle;
        exp = expected_resp(t.addr, t.count);
        @(posedge clk);
        req_valid <= 1'b1;
        req.addr  <= t.addr;
        req.count <= fetch_count_t'(t.count);
        if (t.kind == HOLD) begin
            resp_ready <= 1'b0;
        end
        do @(negedge clk); while (!req_ready);
        @(posedge clk); // Accepting edge.
        req_valid <= 1'b0;
        @(negedge clk);
        accept_cycle = cycles;
        if (req_ready) begin
            note_failure({t.name, ": req_ready still high after the request was accepted"});
        end
        while (!resp_valid) @(negedge clk);
        if (t.expects_miss) begin
            exp_ars++;
            check_addr({t.name, " ar address"}, t.addr & ~paddr_t'(4'hf), last_addr);
        end else begin
            check_count({t.name, " hit latency"}, HIT_LATENCY, cycles - accept_cycle);
        end
        check_miss_count({t.name, " ar count"}, exp_ars, ar_count);
        check_resp(t.name, exp, resp);
        if (t.kind == HOLD) begin
            held = resp;
            repeat (HOLD_CYCLES) begin
                @(negedge clk);
                if (!resp_valid || (resp !== held)) begin
                    note_failure({t.name, ": the response changed while resp_ready was low"});
                end
                if (req_ready) begin
                    note_failure({t.name, ": req_ready rose before the response completed"});
                end
            end
            @(posedge clk);
            resp_ready <= 1'b1;
            @(negedge clk);
        end
        exp_resps++;
        @(negedge clk);
        if (resp_valid) begin
            note_failure({t.name, ": resp_valid stayed high after the handshake"});
        end
        check_count({t.name, " response handshakes"}, exp_resps, resp_count);
    endtask

    task automatic run_fence(input test_t t);
        int fence_cycle;
        @(posedge clk);
        fence_req <= 1'b1;
        @(posedge clk); // The cache takes the pulse here.
        fence_req <= 1'b0;
        @(negedge clk);
        fence_cycle = cycles;
        if (req_ready) begin
            note_failure({t.name, ": req_ready high during the fence sweep"});
        end
        while (!fence_done) @(negedge clk);
        check_count({t.name, " fence_done delay"}, `ICACHE_SETS + 1, cycles - fence_cycle);
        exp_fences++;
        @(negedge clk);
        if (fence_done) begin
            note_failure({t.name, ": fence_done stayed high for more than one cycle"});
        end
        check_count({t.name, " fence_done pulses"}, exp_fences, fence_count);
    endtask

    initial begin
        int fences;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b1;
        fence_req  = 1'b0;
        void'($urandom(32'hfe92_935a));
        fences     = 0;
        build_table();
        foreach (tests[i]) begin
            if (tests[i].kind == FENCE) begin
                fences++;
            end
        end
        timeout_limit = RESET_CYCLES + tests.size() * TEST_BUDGET +
                        fences * (`ICACHE_SETS + 2);
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (!req_ready || resp_valid || ar_valid || fence_done) begin
            note_failure("the handshake outputs did not come out of reset idle");
        end
        foreach (tests[i]) begin
            if (tests[i].kind == FENCE) begin
                run_fence(tests[i]);
            end else begin
                run_fetch(tests[i]);
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_count("total fence_done pulses", exp_fences, fence_count);
        $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                 checks, mismatches, failures);
        if ((mismatches == 0) && (failures == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/mem_model.sv */
`default_nettype none

`include "icache_defs.svh"

module mem_model (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ar_valid,
    input  mem_bus_pkg::mem_ar_t ar,
    output logic                 ar_ready,
    output logic                 r_valid,
    output mem_bus_pkg::mem_r_t  r,
    output int                   ar_count,
    output icache_pkg::paddr_t   last_addr
);
    timeunit 1ns;
    timeprecision 1ps;
    import icache_pkg::*;
    import mem_bus_pkg::*;

    logic        busy;
    int unsigned wait_cnt;
    int          beat;

    // One burst at a time; the next ar is taken only after the last beat.
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ar_ready  <= 1'b1;
            r_valid   <= 1'b0;
            r         <= '0;
            ar_count  <= 0;
            last_addr <= '0;
            busy      <= 1'b0;
            wait_cnt  <= 0;
            beat      <= 0;
        end else begin
            r_valid <= 1'b0;
            if (!busy) begin
                if (ar_valid && ar_ready) begin
                    busy      <= 1'b1;
                    ar_ready  <= 1'b0;
                    last_addr <= ar.addr;
                    wait_cnt  <= $urandom_range(7, 0); // Latency before the first beat.
                    beat      <= 0;
                    ar_count  <= ar_count + 1;
                end
            end else if (wait_cnt != 0) begin
                wait_cnt <= wait_cnt - 1;
            end else begin
                r_valid <= 1'b1;
                r.data  <= ~(last_addr + paddr_t'(4 * beat)); // Inverted byte address.
                r.last  <= (beat == `ICACHE_LINE_WORDS - 1);
                beat    <= beat + 1;
                if (beat == `ICACHE_LINE_WORDS - 1) begin
                    busy     <= 1'b0;
                    ar_ready <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* icache/icache_top.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  icache_pkg::fetch_req_t   req,
    output logic                     req_ready,
    output logic                     resp_valid,
    output icache_pkg::fetch_resp_t  resp,
    input  logic                     resp_ready,
    output logic                     ar_valid,
    output mem_bus_pkg::mem_ar_t     ar,
    input  logic                     ar_ready,
    input  logic                     r_valid,
    input  mem_bus_pkg::mem_r_t      r,
    input  logic                     fence_req,
    output logic                     fence_done
);
    import icache_pkg::*;

    logic                           accept;
    lookup_t                        lookup;
    logic                           read_en;
    logic                           fill_en;
    way_t                           fill_way;
    word_t [`ICACHE_LINE_WORDS-1:0] fill_line;
    logic                           touch_en;
    way_t                           touch_way;
    logic                           hit;
    way_t                           hit_way;
    way_t                           lru_way;
    word_t [`ICACHE_LINE_WORDS-1:0] hit_words;
    logic                           sweeping;
    word_t [`ICACHE_LINE_WORDS-1:0] refill_line;
    logic                           refill_done;
    logic                           lookup_hit;

    fetch_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .accept    (accept),
        .lookup    (lookup)
    );

    icache_arrays u_arrays (
        .clk        (clk),
        .rst        (rst),
        .lookup     (lookup),
        .read_en    (read_en),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_line  (fill_line),
        .touch_en   (touch_en),
        .touch_way  (touch_way),
        .fence_req  (fence_req),
        .hit        (hit),
        .hit_way    (hit_way),
        .lru_way    (lru_way),
        .hit_words  (hit_words),
        .sweeping   (sweeping),
        .fence_done (fence_done)
    );

    miss_control u_miss (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .resp_ready  (resp_ready),
        .hit         (hit),
        .hit_way     (hit_way),
        .lru_way     (lru_way),
        .lookup      (lookup),
        .sweeping    (sweeping),
        .ar_ready    (ar_ready),
        .r_valid     (r_valid),
        .r           (r),
        .accept      (accept),
        .req_ready   (req_ready),
        .read_en     (read_en),
        .fill_en     (fill_en),
        .fill_way    (fill_way),
        .fill_line   (fill_line),
        .touch_en    (touch_en),
        .touch_way   (touch_way),
        .ar_valid    (ar_valid),
        .ar          (ar),
        .refill_line (refill_line),
        .refill_done (refill_done),
        .lookup_hit  (lookup_hit)
    );

    fetch_response u_resp (
        .clk         (clk),
        .rst         (rst),
        .lookup      (lookup),
        .lookup_hit  (lookup_hit),
        .refill_done (refill_done),
        .hit_words   (hit_words),
        .refill_line (refill_line),
        .resp_ready  (resp_ready),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

endmodule

`default_nettype wire

/* icache/fetch_response.sv */
`default_nettype none

`include "icache_defs.svh"

module fetch_response (
    input  logic                                       clk,
    input  logic                                       rst,
    input  icache_pkg::lookup_t                        lookup,
    input  logic                                       lookup_hit,
    input  logic                                       refill_done,
    input  icache_pkg::word_t [`ICACHE_LINE_WORDS-1:0] hit_words,
    input  icache_pkg::word_t [`ICACHE_LINE_WORDS-1:0] refill_line,
    input  logic                                       resp_ready,
    output logic                                       resp_valid,
    output icache_pkg::fetch_resp_t                    resp
);
    import icache_pkg::*;

    word_t [`ICACHE_LINE_WORDS-1:0] src_line;
    fetch_resp_t                    resp_next;
    logic                           load;

    assign load     = lookup_hit || refill_done;
    assign src_line = refill_done ? refill_line : hit_words;

    // Response word i is line word offset+i, zeroed outside the mask.
    always_comb begin
        int idx;
        resp_next.en = lookup.en;
        for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
            idx = int'(lookup.offset) + i;
            if ((idx < `ICACHE_LINE_WORDS) && lookup.en[i]) begin
                resp_next.words[i] = src_line[idx];
            end else begin
                resp_next.words[i] = '0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (load) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    // Held while resp_ready is low; no new load can come until the handshake.
    always_ff @(posedge clk) begin
        if (load) begin
            resp <= resp_next;
        end
    end

endmodule

`default_nettype wire

/* icache/miss_control.sv */
`default_nettype none

`include "icache_defs.svh"

module miss_control (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       req_valid,
    input  logic                                       resp_ready,
    input  logic                                       hit,
    input  icache_pkg::way_t                           hit_way,
    input  icache_pkg::way_t                           lru_way,
    input  icache_pkg::lookup_t                        lookup,
    input  logic                                       sweeping,
    input  logic                                       ar_ready,
    input  logic                                       r_valid,
    input  mem_bus_pkg::mem_r_t                        r,
    output logic                                       accept,
    output logic                                       req_ready,
    output logic                                       read_en,
    output logic                                       fill_en,
    output icache_pkg::way_t                           fill_way,
    output icache_pkg::word_t [`ICACHE_LINE_WORDS-1:0] fill_line,
    output logic                                       touch_en,
    output icache_pkg::way_t                           touch_way,
    output logic                                       ar_valid,
    output mem_bus_pkg::mem_ar_t                       ar,
    output icache_pkg::word_t [`ICACHE_LINE_WORDS-1:0] refill_line,
    output logic                                       refill_done,
    output logic                                       lookup_hit
);
    import icache_pkg::*;

    ctrl_state_t                    state;
    logic                           lookup_wait;  // First LOOKUP cycle, arrays still reading.
    logic                           resp_pending;
    logic                           lookup_miss;
    word_off_t                      beat_idx;
    word_t [`ICACHE_LINE_WORDS-1:0] refill_buf;

    assign req_ready   = (state == IDLE) && !sweeping && !resp_pending;
    assign accept      = req_valid && req_ready;
    assign read_en     = (state == LOOKUP) && lookup_wait;
    assign lookup_hit  = (state == LOOKUP) && !lookup_wait && hit;
    assign lookup_miss = (state == LOOKUP) && !lookup_wait && !hit;
    assign ar_valid    = (state == MISS);

    // The last beat goes straight into the line written to the arrays.
    assign fill_en     = (state == REFILL) && r_valid && r.last;
    assign refill_done = fill_en;

    always_comb begin
        fill_line           = refill_buf;
        fill_line[beat_idx] = r.data;
    end

    assign refill_line = fill_line;
    assign touch_en    = lookup_hit || fill_en;
    assign touch_way   = fill_en ? fill_way : hit_way;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            lookup_wait  <= 1'b0;
            resp_pending <= 1'b0;
            beat_idx     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state       <= LOOKUP;
                        lookup_wait <= 1'b1;
                    end
                end
                LOOKUP: begin
                    if (lookup_wait) begin
                        lookup_wait <= 1'b0;
                    end else if (hit) begin
                        state <= IDLE;
                    end else begin
                        state <= MISS;
                    end
                end
                MISS: begin
                    if (ar_ready) begin
                        state    <= REFILL;
                        beat_idx <= '0;
                    end
                end
                REFILL: begin
                    if (r_valid) begin
                        beat_idx <= beat_idx + 1'b1;
                        if (r.last) begin
                            state <= IDLE;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
            // Mirrors resp_valid in fetch_response.
            if (lookup_hit || refill_done) begin
                resp_pending <= 1'b1;
            end else if (resp_ready) begin
                resp_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_miss) begin
            ar.addr  <= {lookup.tag, lookup.set_idx, {`ICACHE_LINE_BYTE_BITS{1'b0}}};
            fill_way <= lru_way;
        end
        if ((state == REFILL) && r_valid) begin
            refill_buf[beat_idx] <= r.data;
        end
    end

endmodule

`default_nettype wire

/* icache/icache_arrays.sv */
`default_nettype none

`include "icache_defs.svh"

module icache_arrays (
    input  logic                                       clk,
    input  logic                                       rst,
    input  icache_pkg::lookup_t                        lookup,
    input  logic                                       read_en,
    input  logic                                       fill_en,
    input  icache_pkg::way_t                           fill_way,
    input  icache_pkg::word_t [`ICACHE_LINE_WORDS-1:0] fill_line,
    input  logic                                       touch_en,
    input  icache_pkg::way_t                           touch_way,
    input  logic                                       fence_req,
    output logic                                       hit,
    output icache_pkg::way_t                           hit_way,
    output icache_pkg::way_t                           lru_way,
    output icache_pkg::word_t [`ICACHE_LINE_WORDS-1:0] hit_words,
    output logic                                       sweeping,
    output logic                                       fence_done
);
    import icache_pkg::*;

    // One extra count past the last set gives the cycle that raises fence_done.
    localparam int SWEEP_BITS = `ICACHE_SET_BITS + 1;

    tag_t                           tag_mem  [`ICACHE_WAYS][`ICACHE_SETS];
    word_t [`ICACHE_LINE_WORDS-1:0] data_mem [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid;
    logic [`ICACHE_SETS-1:0]        lru;    // Per set, the way used least recently.

    tag_t                           rd_tag   [`ICACHE_WAYS];
    word_t [`ICACHE_LINE_WORDS-1:0] rd_data  [`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0]        rd_valid;
    logic [`ICACHE_WAYS-1:0]        way_hit;
    logic [SWEEP_BITS-1:0]          sweep_cnt;

    // Storage writes and the synchronous read port.
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_way][lookup.set_idx]  <= lookup.tag;
            data_mem[fill_way][lookup.set_idx] <= fill_line;
        end
        if (read_en) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                rd_tag[w]  <= tag_mem[w][lookup.set_idx];
                rd_data[w] <= data_mem[w][lookup.set_idx];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid      <= '0;
            lru        <= '0;
            rd_valid   <= '0;
            sweeping   <= 1'b0;
            sweep_cnt  <= '0;
            fence_done <= 1'b0;
        end else begin
            fence_done <= 1'b0;
            if (read_en) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    rd_valid[w] <= valid[w][lookup.set_idx];
                end
            end
            if (fence_req) begin
                sweeping  <= 1'b1;
                sweep_cnt <= '0;
            end else if (sweeping) begin
                if (sweep_cnt == SWEEP_BITS'(`ICACHE_SETS)) begin
                    sweeping   <= 1'b0;
                    fence_done <= 1'b1;
                end else begin
                    for (int w = 0; w < `ICACHE_WAYS; w++) begin
                        valid[w][sweep_cnt[`ICACHE_SET_BITS-1:0]] <= 1'b0;
                    end
                    sweep_cnt <= sweep_cnt + 1'b1;
                end
            end
            if (fill_en) begin
                valid[fill_way][lookup.set_idx] <= 1'b1;
            end
            if (touch_en) begin
                lru[lookup.set_idx] <= ~touch_way; // Two ways, so the other one becomes LRU.
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_hit[w] = rd_valid[w] && (rd_tag[w] == lookup.tag);
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit       = |way_hit;
    assign hit_words = rd_data[hit_way];
    assign lru_way   = way_t'(lru[lookup.set_idx]);

endmodule

`default_nettype wire

/* icache/fetch_decode.sv */
`default_nettype none

`include "icache_defs.svh"

module fetch_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  icache_pkg::fetch_req_t req,
    input  logic                   accept,
    output icache_pkg::lookup_t    lookup
);
    import icache_pkg::*;

    lookup_t      lookup_next;
    fetch_count_t room;

    // Words left in the line from the start offset; a block never crosses the line.
    assign room = fetch_count_t'(`ICACHE_LINE_WORDS) - fetch_count_t'(lookup_next.offset);

    always_comb begin
        lookup_next.set_idx = req.addr[`ICACHE_LINE_BYTE_BITS +: `ICACHE_SET_BITS];
        lookup_next.tag     = req.addr[`ICACHE_PADDR_WIDTH-1 -: `ICACHE_TAG_BITS];
        lookup_next.offset  = req.addr[`ICACHE_BYTE_BITS +: `ICACHE_OFF_BITS];
        for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
            lookup_next.en[i] = (fetch_count_t'(i) < req.count) &&
                                (fetch_count_t'(i) < room);
        end
    end

    // The registered request stays put until the next accepted fetch.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lookup <= '0;
        end else if (req_valid && accept) begin
            lookup <= lookup_next;
        end
    end

endmodule

`default_nettype wire

/* common/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    // Read burst request; the address is always line aligned.
    typedef struct packed {
        icache_pkg::paddr_t addr;
    } mem_ar_t;

    // One read beat of the burst.
    typedef struct packed {
        icache_pkg::word_t data;
        logic              last; // Marks the final word of the line.
    } mem_r_t;

endpackage

`default_nettype wire

/* common/icache_pkg.sv */
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

    typedef logic [`ICACHE_PADDR_WIDTH-1:0] paddr_t;
    typedef logic [`ICACHE_WORD_WIDTH-1:0]  word_t;
    typedef logic [`ICACHE_SET_BITS-1:0]    set_idx_t;
    typedef logic [`ICACHE_TAG_BITS-1:0]    tag_t;
    typedef logic [`ICACHE_OFF_BITS-1:0]    word_off_t;
    typedef logic [`ICACHE_COUNT_BITS-1:0]  fetch_count_t;
    typedef logic [`ICACHE_WAY_BITS-1:0]    way_t;

    typedef struct packed {
        paddr_t       addr;
        fetch_count_t count; // Number of instructions wanted, 1 to LINE_WORDS.
    } fetch_req_t;

    typedef struct packed {
        word_t [`ICACHE_LINE_WORDS-1:0] words;
        logic  [`ICACHE_LINE_WORDS-1:0] en;
    } fetch_resp_t;

    typedef struct packed {
        set_idx_t                       set_idx;
        tag_t                           tag;
        word_off_t                      offset;
        logic  [`ICACHE_LINE_WORDS-1:0] en;
    } lookup_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL
    } ctrl_state_t;

endpackage

`default_nettype wire

/* common/icache_defs.svh */
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Cache geometry.
`define ICACHE_WAYS        2
`define ICACHE_SETS        16
`define ICACHE_LINE_WORDS  4
`define ICACHE_PADDR_WIDTH 32
`define ICACHE_WORD_WIDTH  32

// Field widths derived from the geometry above.
`define ICACHE_WAY_BITS       ($clog2(`ICACHE_WAYS))
`define ICACHE_SET_BITS       ($clog2(`ICACHE_SETS))
`define ICACHE_OFF_BITS       ($clog2(`ICACHE_LINE_WORDS))
`define ICACHE_BYTE_BITS      2
`define ICACHE_LINE_BYTE_BITS (`ICACHE_OFF_BITS + `ICACHE_BYTE_BITS)
`define ICACHE_TAG_BITS       (`ICACHE_PADDR_WIDTH - `ICACHE_SET_BITS - `ICACHE_LINE_BYTE_BITS)

// Count of 1 to LINE_WORDS needs one bit more than the offset.
`define ICACHE_COUNT_BITS     (`ICACHE_OFF_BITS + 1)

`endif
